// ==== source/cpu_pkg.sv ====
// shared types only; pipeline structs are packed, so their field order is the bit layout
`default_nettype none

package cpu_pkg;

    // data path word
    typedef logic [31:0] word_t;

    // register write and forwarding source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_NPC  = 2'd1,
        WB_LOAD = 2'd2,
        WB_IMM  = 2'd3
    } wb_src_t;

    // execute/memory pipeline register
    typedef struct packed {
        logic        reg_wen;
        wb_src_t     wb_src;
        logic        halt;
        logic        dren;
        logic        dwen;
        logic        atomic;
        logic        beq;
        logic        bne;
        logic        zero;
        // predicted outcome from fetch
        logic        branch_taken;
        logic        emergency_flush;
        logic        jump_sel;
        logic [4:0]  rw;
        word_t       pc;
        word_t       npc;
        word_t       port_a;
        word_t       port_b;
        word_t       port_o;
        word_t       imm_ext;
        word_t       branch_addr;
        word_t       instruction;
    } execute_t;

    // memory/writeback pipeline register
    typedef struct packed {
        logic        reg_wen;
        wb_src_t     wb_src;
        logic        halt;
        logic [4:0]  rw;
        word_t       npc;
        word_t       port_o;
        word_t       imm_ext;
        word_t       dmemload;
    } memory_t;

endpackage

`default_nettype wire

// ==== source/memory_stage_if.sv ====
// no handshake; ihit, freeze and flush are plain strobes and dhit marks returned data
`timescale 1ns/1ps
`default_nettype none

interface memory_stage_if
    import cpu_pkg::*;
();

    // pipeline control from the top
    logic      ihit;
    logic      freeze;
    logic      flush;

    // pipeline registers
    execute_t  execute_p;
    memory_t   memory_p;

    // data memory request
    logic      dmem_ren;
    logic      dmem_wen;
    word_t     dmem_addr;
    word_t     dmem_store;
    logic      atomic;

    // data memory response
    word_t     dmem_load;
    logic      dhit;

    modport latch (
        input  ihit, freeze, flush,
        output execute_p
    );

    modport mem (
        input  ihit, freeze, flush, execute_p, dmem_load, dhit,
        output memory_p, dmem_ren, dmem_wen, dmem_addr, dmem_store, atomic
    );

    // atomic reaches the memory port with no reservation behind it
    modport ram (
        input  dmem_ren, dmem_wen, dmem_addr, dmem_store, atomic,
        output dmem_load, dhit
    );

    modport wb (
        input  memory_p
    );

endinterface

`default_nettype wire

// ==== source/execute_latch.sv ====
// execute results arrive already formed at ex_in; flush beats freeze, freeze beats ihit
`timescale 1ns/1ps
`default_nettype none

module execute_latch
    import cpu_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    memory_stage_if.latch      mif,
    input  execute_t           ex_in
);

    execute_t next_execute;

    // pick the next register value
    always_comb begin
        next_execute = mif.execute_p;
        if (mif.flush) begin
            next_execute = '0;
        end else if (mif.freeze) begin
            next_execute = mif.execute_p;
        end else if (mif.ihit) begin
            next_execute = ex_in;
        end
    end

    // execute/memory register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mif.execute_p <= '0;
        end else begin
            mif.execute_p <= next_execute;
        end
    end

endmodule

`default_nettype wire

// ==== source/memory_stage.sv ====
// single-cycle data memory assumed; fwd_data gives zero for loads since data is not back yet
`timescale 1ns/1ps
`default_nettype none

module memory_stage
    import cpu_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    memory_stage_if.mem        mif,
    output logic               branch_taken,
    output logic               branch_mispredict,
    output logic               jump_sel,
    output word_t              branch_addr,
    output word_t              jump_addr,
    output word_t              pc_out,
    output word_t              port_a_out,
    output word_t              fwd_data
);

    execute_t ep;
    memory_t  next_memory;
    word_t    dmemload_q;
    logic     is_branch;

    assign ep = mif.execute_p;

    // data memory request with stores blocked on halt
    assign mif.dmem_ren   = ep.dren;
    assign mif.dmem_wen   = ep.dwen & ~ep.halt;
    assign mif.dmem_addr  = ep.port_o;
    assign mif.dmem_store = ep.port_b;
    assign mif.atomic     = ep.atomic;

    // branch resolution
    assign is_branch    = ep.beq | ep.bne;
    assign branch_taken = (ep.beq & ep.zero) | (ep.bne & ~ep.zero);
    // a taken prediction under emergency flush also counts as a miss
    assign branch_mispredict = is_branch &
        ((ep.branch_taken != branch_taken) | (ep.branch_taken & ep.emergency_flush));

    assign branch_addr = ep.branch_addr;
    assign jump_sel    = ep.jump_sel;
    assign jump_addr   = {ep.npc[31:28], ep.instruction[25:0], 2'b00};
    assign pc_out      = ep.pc;
    assign port_a_out  = ep.port_a;

    // forwarding source
    always_comb begin
        case (ep.wb_src)
            WB_ALU:  fwd_data = ep.port_o;
            WB_NPC:  fwd_data = ep.npc;
            WB_LOAD: fwd_data = '0;
            WB_IMM:  fwd_data = ep.imm_ext;
        endcase
    end

    // hold load data until the next ihit moves it on
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dmemload_q <= '0;
        end else if (mif.dhit) begin
            dmemload_q <= mif.dmem_load;
        end
    end

    always_comb begin
        next_memory.reg_wen  = ep.reg_wen;
        next_memory.wb_src   = ep.wb_src;
        next_memory.halt     = ep.halt;
        next_memory.rw       = ep.rw;
        next_memory.npc      = ep.npc;
        next_memory.port_o   = ep.port_o;
        next_memory.imm_ext  = ep.imm_ext;
        next_memory.dmemload = dmemload_q;
    end

    // memory/writeback register
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mif.memory_p <= '0;
        end else if (mif.flush) begin
            mif.memory_p <= '0;
        end else if (!mif.freeze && mif.ihit) begin
            mif.memory_p <= next_memory;
        end
    end

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
// word addressed, byte offset ignored; fixed one-cycle response with no wait states
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import cpu_pkg::*;
#(
    parameter int DATA_ADDR_BITS = 8
)
(
    input  logic               CLK,
    input  logic               nRST,
    memory_stage_if.ram        mif
);

    localparam int DEPTH = 1 << DATA_ADDR_BITS;

    word_t                      mem [DEPTH];
    logic [DATA_ADDR_BITS-1:0]  word_idx;
    logic                       request;

    assign word_idx = mif.dmem_addr[DATA_ADDR_BITS+1:2];
    assign request  = mif.dmem_ren | mif.dmem_wen;

    // storage array
    always_ff @(posedge CLK) begin
        if (mif.dmem_wen) begin
            mem[word_idx] <= mif.dmem_store;
        end
    end

    // registered read word and hit strobe
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mif.dmem_load <= '0;
            mif.dhit      <= 1'b0;
        end else begin
            mif.dhit <= request;
            if (mif.dmem_ren) begin
                mif.dmem_load <= mem[word_idx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/writeback_stage.sv ====
// halted is sticky until reset; register writes are suppressed on a halt entry
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
    import cpu_pkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    memory_stage_if.wb         mif,
    output logic               reg_wen,
    output logic [4:0]         reg_dest,
    output word_t              reg_data,
    output logic               halted
);

    memory_t mp;

    assign mp       = mif.memory_p;
    assign reg_wen  = mp.reg_wen & ~mp.halt;
    assign reg_dest = mp.rw;

    // register write data
    always_comb begin
        case (mp.wb_src)
            WB_ALU:  reg_data = mp.port_o;
            WB_NPC:  reg_data = mp.npc;
            WB_LOAD: reg_data = mp.dmemload;
            WB_IMM:  reg_data = mp.imm_ext;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halted <= 1'b0;
        end else if (mp.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_subsystem_top.sv ====
// execute results and pipeline strobes come straight from ports; no fetch, decode or hazard unit
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
    import cpu_pkg::*;
#(
    parameter int DATA_ADDR_BITS = 8
)
(
    input  logic        CLK,
    input  logic        nRST,
    input  logic        ihit,
    input  logic        freeze,
    input  logic        flush,
    input  execute_t    ex_in,
    output logic        branch_taken,
    output logic        branch_mispredict,
    output logic        jump_sel,
    output word_t       branch_addr,
    output word_t       jump_addr,
    output word_t       pc_out,
    output word_t       port_a_out,
    output word_t       fwd_data,
    output logic        reg_wen,
    output logic [4:0]  reg_dest,
    output word_t       reg_data,
    output logic        halted
);

    memory_stage_if mif ();

    // pipeline strobes onto the shared interface
    assign mif.ihit   = ihit;
    assign mif.freeze = freeze;
    assign mif.flush  = flush;

    execute_latch u_execute_latch (
        .CLK   (CLK),
        .nRST  (nRST),
        .mif   (mif.latch),
        .ex_in (ex_in)
    );

    memory_stage u_memory_stage (
        .CLK               (CLK),
        .nRST              (nRST),
        .mif               (mif.mem),
        .branch_taken      (branch_taken),
        .branch_mispredict (branch_mispredict),
        .jump_sel          (jump_sel),
        .branch_addr       (branch_addr),
        .jump_addr         (jump_addr),
        .pc_out            (pc_out),
        .port_a_out        (port_a_out),
        .fwd_data          (fwd_data)
    );

    data_ram #(
        .DATA_ADDR_BITS (DATA_ADDR_BITS)
    ) u_data_ram (
        .CLK  (CLK),
        .nRST (nRST),
        .mif  (mif.ram)
    );

    writeback_stage u_writeback_stage (
        .CLK      (CLK),
        .nRST     (nRST),
        .mif      (mif.wb),
        .reg_wen  (reg_wen),
        .reg_dest (reg_dest),
        .reg_data (reg_data),
        .halted   (halted)
    );

endmodule

`default_nettype wire

// ==== verification/clock_gen.sv ====
// reset is released 1 ns after the 16th rising edge; a pulse on reset_req starts it again
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic CLK,
    output logic nRST,
    input  logic reset_req
);

    localparam time PERIOD       = 20ns;
    localparam int  RESET_CYCLES = 16;

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // active-low reset repeated on request
    always begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1 nRST = 1'b1;
        @(posedge reset_req);
    end

endmodule

`default_nettype wire

// ==== verification/mem_subsystem_assertions.sv ====
// sampled on the rising clock; the dhit check assumes the fixed one-cycle data memory
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_assertions (
    input logic CLK,
    input logic nRST,
    input logic beq,
    input logic bne,
    input logic halt,
    input logic dmem_ren,
    input logic dmem_wen,
    input logic dhit,
    input logic branch_taken,
    input logic branch_mispredict,
    input logic jump_sel
);

    int fail_count = 0;

    mispredict_needs_branch: assert property (
        @(posedge CLK) disable iff (!nRST) branch_mispredict |-> (beq || bne)
    ) else begin
        fail_count++;
        $error("branch_mispredict raised without beq or bne");
    end

    no_store_on_halt: assert property (
        @(posedge CLK) disable iff (!nRST) dmem_wen |-> !halt
    ) else begin
        fail_count++;
        $error("dmem_wen active while halt is set");
    end

    // one-cycle response
    dhit_after_request: assert property (
        @(posedge CLK) disable iff (!nRST) (dmem_ren || dmem_wen) |=> dhit
    ) else begin
        fail_count++;
        $error("dhit missing one cycle after a data memory request");
    end

    quiet_in_reset: assert property (
        @(posedge CLK) !nRST |->
            !(dmem_ren || dmem_wen || branch_taken || branch_mispredict || jump_sel)
    ) else begin
        fail_count++;
        $error("request or branch output active during reset");
    end

endmodule

`default_nettype wire

// ==== verification/mem_subsystem_tb.sv ====
// execute results are driven straight onto ex_in; the memory model assumes 8 word-address bits
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb
    import cpu_pkg::*;
();

    localparam int ADDR_BITS     = 8;
    localparam int DHIT_TIMEOUT  = 10;
    localparam int RESET_TIMEOUT = 40;
    localparam int N_STORES      = 6;

    logic       CLK;
    logic       nRST;
    logic       reset_req;
    logic       ihit;
    logic       freeze;
    logic       flush;
    execute_t   ex_in;
    logic       branch_taken;
    logic       branch_mispredict;
    logic       jump_sel;
    word_t      branch_addr;
    word_t      jump_addr;
    word_t      pc_out;
    word_t      port_a_out;
    word_t      fwd_data;
    logic       reg_wen;
    logic [4:0] reg_dest;
    word_t      reg_data;
    logic       halted;

    word_t      rng_state;
    word_t      model_mem [int];
    word_t      held_load;
    execute_t   prev_entry;
    word_t      prev_load;
    string      test_name;
    int         value_errors;
    int         other_errors;

    clock_gen u_clock_gen (
        .CLK       (CLK),
        .nRST      (nRST),
        .reset_req (reset_req)
    );

    mem_subsystem_top #(
        .DATA_ADDR_BITS (ADDR_BITS)
    ) uut (
        .CLK               (CLK),
        .nRST              (nRST),
        .ihit              (ihit),
        .freeze            (freeze),
        .flush             (flush),
        .ex_in             (ex_in),
        .branch_taken      (branch_taken),
        .branch_mispredict (branch_mispredict),
        .jump_sel          (jump_sel),
        .branch_addr       (branch_addr),
        .jump_addr         (jump_addr),
        .pc_out            (pc_out),
        .port_a_out        (port_a_out),
        .fwd_data          (fwd_data),
        .reg_wen           (reg_wen),
        .reg_dest          (reg_dest),
        .reg_data          (reg_data),
        .halted            (halted)
    );

    bind memory_stage mem_subsystem_assertions u_assert (
        .CLK               (CLK),
        .nRST              (nRST),
        .beq               (ep.beq),
        .bne               (ep.bne),
        .halt              (ep.halt),
        .dmem_ren          (mif.dmem_ren),
        .dmem_wen          (mif.dmem_wen),
        .dhit              (mif.dhit),
        .branch_taken      (branch_taken),
        .branch_mispredict (branch_mispredict),
        .jump_sel          (jump_sel)
    );

    function automatic word_t xorshift(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // random entry with no memory request and no halt
    function automatic execute_t rand_entry();
        execute_t e;
        word_t    r;
        e = '0;
        r = rand_word();
        e.reg_wen         = r[0];
        e.wb_src          = wb_src_t'(r[2:1]);
        e.atomic          = r[3];
        e.beq             = r[4];
        e.bne             = r[5];
        e.zero            = r[6];
        e.branch_taken    = r[7];
        e.emergency_flush = r[8];
        e.jump_sel        = r[9];
        e.rw              = r[14:10];
        e.pc              = rand_word();
        e.npc             = rand_word();
        e.port_a          = rand_word();
        e.port_b          = rand_word();
        e.port_o          = rand_word();
        e.imm_ext         = rand_word();
        e.branch_addr     = rand_word();
        e.instruction     = rand_word();
        return e;
    endfunction

    function automatic int word_index(input word_t addr);
        return int'((addr >> 2) & ((1 << ADDR_BITS) - 1));
    endfunction

    // write data by source with the loaded word only for WB_LOAD
    function automatic word_t select_source(input execute_t e, input word_t loaded);
        if (e.wb_src == WB_ALU) return e.port_o;
        if (e.wb_src == WB_NPC) return e.npc;
        if (e.wb_src == WB_LOAD) return loaded;
        return e.imm_ext;
    endfunction

    task automatic step_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, name, expected, actual);
        end
    endtask

    task automatic check_stage(input execute_t e);
        logic taken;
        logic miss;
        // beq resolves on zero and bne on nonzero
        taken = e.zero ? e.beq : e.bne;
        if (!(e.beq || e.bne)) begin
            miss = 1'b0;
        end else if (e.branch_taken) begin
            miss = !taken || e.emergency_flush;
        end else begin
            miss = taken;
        end
        check_value("fwd_data", select_source(e, '0), fwd_data);
        check_value("branch_taken", taken, branch_taken);
        check_value("branch_mispredict", miss, branch_mispredict);
        check_value("branch_addr", e.branch_addr, branch_addr);
        check_value("pc_out", e.pc, pc_out);
        check_value("port_a_out", e.port_a, port_a_out);
        check_value("jump_sel", e.jump_sel, jump_sel);
        check_value("jump_addr",
            (e.npc & 32'hf000_0000) | ({6'd0, e.instruction[25:0]} << 2), jump_addr);
    endtask

    task automatic check_writeback(input execute_t p, input word_t loaded);
        check_value("reg_wen", p.reg_wen && !p.halt, reg_wen);
        check_value("reg_dest", p.rw, reg_dest);
        check_value("reg_data", select_source(p, loaded), reg_data);
    endtask

    // one ihit pulse followed by the wait for the memory response
    task automatic issue(input execute_t e);
        int waited;
        ex_in = e;
        ihit  = 1'b1;
        step_cycle();
        ihit = 1'b0;
        step_cycle();
        if (e.dren || (e.dwen && !e.halt)) begin
            waited = 0;
            while (uut.mif.dhit !== 1'b1 && waited < DHIT_TIMEOUT) begin
                step_cycle();
                waited++;
            end
            if (uut.mif.dhit !== 1'b1) begin
                other_errors++;
                $display("%s: dhit never came after a data memory request", test_name);
            end
        end
        step_cycle();
        step_cycle();
    endtask

    task automatic issue_and_check(input execute_t e);
        int idx;
        idx = word_index(e.port_o);
        if (e.dren) begin
            held_load = model_mem.exists(idx) ? model_mem[idx] : '0;
        end
        if (e.dwen && !e.halt) begin
            model_mem[idx] = e.port_b;
        end
        issue(e);
        check_writeback(prev_entry, prev_load);
        check_stage(e);
        prev_entry = e;
        prev_load  = held_load;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (nRST !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge CLK);
            waited++;
        end
        if (nRST !== 1'b1) begin
            other_errors++;
            $display("reset was never released");
        end
        step_cycle();
    endtask

    initial begin
        execute_t e;
        execute_t a;
        word_t    addrs [N_STORES];
        word_t    r;
        word_t    a_load;
        word_t    exp_reg;
        word_t    exp_fwd;
        int       i;
        int       assert_errors;

        rng_state    = 32'h98d73d68;
        reset_req    = 1'b0;
        ihit         = 1'b0;
        freeze       = 1'b0;
        flush        = 1'b0;
        ex_in        = '0;
        held_load    = '0;
        prev_entry   = '0;
        prev_load    = '0;
        value_errors = 0;
        other_errors = 0;
        test_name    = "reset";
        wait_reset_release();

        test_name = "store_load";
        for (i = 0; i < N_STORES; i++) begin
            e = rand_entry();
            e.dwen = 1'b1;
            addrs[i] = e.port_o;
            issue_and_check(e);
        end
        for (i = 0; i < N_STORES; i++) begin
            e = rand_entry();
            r = rand_word();
            e.dren    = 1'b1;
            e.reg_wen = 1'b1;
            e.wb_src  = WB_LOAD;
            // byte offset must not matter
            e.port_o  = addrs[i] ^ {30'd0, r[1:0]};
            issue_and_check(e);
        end

        test_name = "select";
        for (i = 0; i < 12; i++) begin
            issue_and_check(rand_entry());
        end

        test_name = "branch";
        for (i = 0; i < 32; i++) begin
            e = rand_entry();
            e.beq             = i[0];
            e.bne             = i[1];
            e.zero            = i[2];
            e.branch_taken    = i[3];
            e.emergency_flush = i[4];
            issue_and_check(e);
        end

        test_name = "jump";
        for (i = 0; i < 8; i++) begin
            issue_and_check(rand_entry());
        end

        test_name = "halt";
        e = rand_entry();
        e.halt    = 1'b1;
        e.dwen    = 1'b1;
        e.reg_wen = 1'b1;
        e.port_o  = addrs[0];
        e.port_b  = ~model_mem[word_index(addrs[0])];
        issue_and_check(e);
        // old word must still be there
        e = rand_entry();
        e.dren    = 1'b1;
        e.reg_wen = 1'b1;
        e.wb_src  = WB_LOAD;
        e.port_o  = addrs[0];
        issue_and_check(e);
        issue_and_check(rand_entry());
        check_value("halted", 1'b1, halted);
        issue_and_check(rand_entry());
        check_value("halted", 1'b1, halted);
        reset_req = 1'b1;
        step_cycle();
        reset_req = 1'b0;
        wait_reset_release();
        prev_entry = '0;
        prev_load  = '0;
        held_load  = '0;
        check_value("halted after reset", 1'b0, halted);
        check_value("reg_wen after reset", 1'b0, reg_wen);

        test_name = "flush";
        e = rand_entry();
        e.reg_wen      = 1'b1;
        e.wb_src       = WB_ALU;
        e.beq          = 1'b1;
        e.bne          = 1'b0;
        e.zero         = 1'b1;
        e.branch_taken = 1'b0;
        e.jump_sel     = 1'b1;
        issue_and_check(e);
        // same entry again so both stage registers hold it
        issue_and_check(e);
        // flush wins over a concurrent ihit
        ex_in = rand_entry();
        ihit  = 1'b1;
        flush = 1'b1;
        step_cycle();
        ihit  = 1'b0;
        flush = 1'b0;
        check_value("reg_wen", 1'b0, reg_wen);
        check_value("reg_data", '0, reg_data);
        check_value("branch_taken", 1'b0, branch_taken);
        check_value("branch_mispredict", 1'b0, branch_mispredict);
        check_value("jump_sel", 1'b0, jump_sel);
        check_value("fwd_data", '0, fwd_data);
        prev_entry = '0;
        prev_load  = held_load;

        test_name = "freeze";
        a = rand_entry();
        a.reg_wen = 1'b1;
        issue_and_check(a);
        a_load = prev_load;
        issue_and_check(rand_entry());
        exp_reg = select_source(a, a_load);
        exp_fwd = select_source(prev_entry, '0);
        for (i = 0; i < 3; i++) begin
            ex_in  = rand_entry();
            ihit   = 1'b1;
            freeze = 1'b1;
            step_cycle();
            check_value("reg_data", exp_reg, reg_data);
            check_value("fwd_data", exp_fwd, fwd_data);
        end
        ihit   = 1'b0;
        freeze = 1'b0;
        step_cycle();
        issue_and_check(rand_entry());

        repeat (4) step_cycle();
        assert_errors = uut.u_memory_stage.u_assert.fail_count;
        $display("error counts: %0d value, %0d other, %0d assertion",
            value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/cpu_pkg.sv
source/memory_stage_if.sv
source/execute_latch.sv
source/memory_stage.sv
source/data_ram.sv
source/writeback_stage.sv
source/mem_subsystem_top.sv
verification/clock_gen.sv
verification/mem_subsystem_assertions.sv
verification/mem_subsystem_tb.sv
